//--- logic/mm_trg_pkg.sv
package mm_trg_pkg;

  // one converter beat is sixteen 16-bit slots
  localparam int SAMPLE_WIDTH     = 16;
  localparam int SAMPLES_PER_BEAT = 16;
  localparam int TDATA_WIDTH      = SAMPLE_WIDTH * SAMPLES_PER_BEAT;

  // ADC sample sits in the top bits of each slot
  localparam int ADC_WIDTH = 12;

  // baseline-corrected difference needs one extra bit
  localparam int DELTA_WIDTH = ADC_WIDTH + 1;

  // 8 samples per detection window, two windows per beat
  localparam int HIT_WINDOW       = 8;
  localparam int WINDOWS_PER_BEAT = SAMPLES_PER_BEAT / HIT_WINDOW;

  // free-running time and captured time stamp
  localparam int TIME_WIDTH = 48;

  // programmable pre-acquisition length
  localparam int PRE_LEN_WIDTH = 5;

  // fixed hold after the last hit, in cycles
  localparam int POST_ACQUI_LEN = 38;
  localparam int POST_CNT_WIDTH = 7;

  // output word, msb first:
  // data, delayed time, captured baseline, threshold, time stamp
  localparam int DOUT_WIDTH = TDATA_WIDTH
                            + TIME_WIDTH
                            + ADC_WIDTH
                            + DELTA_WIDTH
                            + TIME_WIDTH;

  // trigger FSM states
  typedef enum logic [1:0] {
    ST_DISARMED,
    ST_ARMED,
    ST_FIRED
  } trg_state_e;

endpackage

//--- logic/sample_compare.sv
`timescale 1ns/100ps

module sample_compare (
  input  logic                                      CLK,
  input  logic                                      RESETN,
  input  logic [mm_trg_pkg::TDATA_WIDTH-1:0]        TDATA,
  input  logic                                      TVALID,
  input  logic [mm_trg_pkg::PRE_LEN_WIDTH-1:0]      PRE_ACQUI_LEN,
  input  logic signed [mm_trg_pkg::DELTA_WIDTH-1:0] THRESHOLD_VAL,
  input  logic signed [mm_trg_pkg::ADC_WIDTH-1:0]   BASELINE,
  output logic [mm_trg_pkg::SAMPLES_PER_BEAT-1:0]   hit_bits,
  output logic signed [mm_trg_pkg::ADC_WIDTH-1:0]   baseline_q,
  output logic signed [mm_trg_pkg::DELTA_WIDTH-1:0] threshold_q,
  output logic [mm_trg_pkg::PRE_LEN_WIDTH-1:0]      pre_len_q
);
  import mm_trg_pkg::*;

  logic signed [ADC_WIDTH-1:0]   sample [SAMPLES_PER_BEAT];
  logic signed [DELTA_WIDTH-1:0] delta  [SAMPLES_PER_BEAT];
  logic [SAMPLES_PER_BEAT-1:0]   hit_d;

  // configuration is captured while in reset and held afterwards
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      pre_len_q   <= PRE_ACQUI_LEN;
      baseline_q  <= BASELINE;
      threshold_q <= THRESHOLD_VAL;
    end
  end

  // per-slot unpack, baseline subtraction and threshold compare
  for (genvar i = 0; i < SAMPLES_PER_BEAT; i++) begin : g_slot
    // top 12 bits of the slot, low nibble is padding
    assign sample[i] = TDATA[SAMPLE_WIDTH*i + SAMPLE_WIDTH-1 -: ADC_WIDTH];

    // sign extend both operands so the difference cannot wrap
    assign delta[i] = $signed({sample[i][ADC_WIDTH-1], sample[i]})
                    - $signed({baseline_q[ADC_WIDTH-1], baseline_q});

    assign hit_d[i] = (delta[i] >= threshold_q);
  end

  // invalid beats never contribute hits
  always_ff @(posedge CLK) begin
    if (!RESETN || !TVALID) begin
      hit_bits <= '0;
    end else begin
      hit_bits <= hit_d;
    end
  end

  // a gap in the stream leaves no stale hit bits behind
  a_no_hit_on_gap : assert property (
    @(posedge CLK) disable iff (!RESETN)
    !TVALID |=> (hit_bits == '0)
  );

endmodule

//--- logic/hit_window.sv
`timescale 1ns/100ps

module hit_window (
  input  logic                                    CLK,
  input  logic                                    RESETN,
  input  logic [mm_trg_pkg::SAMPLES_PER_BEAT-1:0] hit_bits,
  input  logic                                    armed,
  output logic                                    hit_echo
);
  import mm_trg_pkg::*;

  logic [WINDOWS_PER_BEAT-1:0] win_hit;
  logic                        hit_flag_d;
  logic                        hit_flag;
  logic                        hit_flag_q;

  // a window hits only if every sample in it is over threshold
  for (genvar w = 0; w < WINDOWS_PER_BEAT; w++) begin : g_win
    assign win_hit[w] = &hit_bits[HIT_WINDOW*w +: HIT_WINDOW];
  end

  assign hit_flag_d = |win_hit;

  // flag and its previous value, both held at zero while disarmed
  always_ff @(posedge CLK) begin
    if (!RESETN || !armed) begin
      hit_flag   <= 1'b0;
      hit_flag_q <= 1'b0;
    end else begin
      hit_flag   <= hit_flag_d;
      hit_flag_q <= hit_flag;
    end
  end

  // stretch every hit to at least two cycles
  assign hit_echo = hit_flag | hit_flag_q;

  // stretched echo survives its first cycle unless the trigger disarms
  a_echo_min_two : assert property (
    @(posedge CLK) disable iff (!RESETN)
    (armed && $rose(hit_echo)) |=> hit_echo
  );

endmodule

//--- logic/trigger_ctrl.sv
`timescale 1ns/100ps

module trigger_ctrl (
  input  logic                                 CLK,
  input  logic                                 RESETN,
  input  logic                                 TVALID,
  input  logic                                 ALL_MODULE_READY,
  input  logic [mm_trg_pkg::PRE_LEN_WIDTH-1:0] pre_len_q,
  input  logic                                 hit_echo,
  output logic                                 armed,
  output logic                                 triggered
);
  import mm_trg_pkg::*;

  logic [PRE_LEN_WIDTH-1:0]  pre_cnt;
  logic                      pre_done;
  logic                      ready_now;
  logic [POST_CNT_WIDTH-1:0] post_cnt;
  logic                      post_done;
  trg_state_e                state;
  trg_state_e                state_nxt;

  assign pre_done  = (pre_cnt == pre_len_q - 1'b1);
  assign post_done = (post_cnt == POST_CNT_WIDTH'(POST_ACQUI_LEN - 1));

  // consecutive valid beats, any gap starts over
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      pre_cnt <= '0;
    end else if (!TVALID) begin
      pre_cnt <= '0;
    end else if (!pre_done) begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  assign ready_now = TVALID & ALL_MODULE_READY & pre_done;

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      armed <= 1'b0;
    end else begin
      armed <= ready_now;
    end
  end

  // post counter restarts on every echo, saturates at the hold length
  always_ff @(posedge CLK) begin
    if (!RESETN || !armed) begin
      post_cnt <= '0;
    end else if (hit_echo) begin
      post_cnt <= '0;
    end else if (!post_done) begin
      post_cnt <= post_cnt + 1'b1;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_DISARMED: begin
        if (armed) begin
          state_nxt = ST_ARMED;
        end
      end
      ST_ARMED: begin
        if (hit_echo) begin
          state_nxt = ST_FIRED;
        end
      end
      ST_FIRED: begin
        // a fresh echo keeps the trigger open
        if (!hit_echo && post_done) begin
          state_nxt = ST_ARMED;
        end
      end
      default: begin
        state_nxt = ST_DISARMED;
      end
    endcase
    // losing readiness overrides everything
    if (!armed) begin
      state_nxt = ST_DISARMED;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state <= ST_DISARMED;
    end else begin
      state <= state_nxt;
    end
  end

  assign triggered = (state == ST_FIRED);

  a_no_rise_disarmed : assert property (
    @(posedge CLK) disable iff (!RESETN)
    $rose(triggered) |-> $past(armed)
  );

  a_post_cnt_bound : assert property (
    @(posedge CLK) disable iff (!RESETN)
    (state == ST_FIRED) |-> (post_cnt <= POST_CNT_WIDTH'(POST_ACQUI_LEN - 1))
  );

endmodule

//--- logic/event_capture.sv
`timescale 1ns/100ps

module event_capture (
  input  logic                                      CLK,
  input  logic                                      RESETN,
  input  logic [mm_trg_pkg::TDATA_WIDTH-1:0]        TDATA,
  input  logic                                      TVALID,
  input  logic [mm_trg_pkg::TIME_WIDTH-1:0]         CURRENT_TIME,
  input  logic                                      triggered,
  input  logic signed [mm_trg_pkg::ADC_WIDTH-1:0]   baseline_q,
  input  logic signed [mm_trg_pkg::DELTA_WIDTH-1:0] threshold_q,
  output logic [mm_trg_pkg::DOUT_WIDTH-1:0]         DOUT,
  output logic                                      VALID
);
  import mm_trg_pkg::*;

  logic [TDATA_WIDTH-1:0] data_q1;
  logic [TDATA_WIDTH-1:0] data_fmt;
  logic [TDATA_WIDTH-1:0] data_q2;
  logic [TDATA_WIDTH-1:0] data_q3;
  logic                   valid_q1;
  logic                   valid_q2;
  logic                   valid_q3;
  logic [TIME_WIDTH-1:0]  time_q1;
  logic [TIME_WIDTH-1:0]  time_q2;
  logic [TIME_WIDTH-1:0]  time_q3;
  logic                   trig_q;
  logic                   trig_rise;
  logic [TIME_WIDTH-1:0]  time_stamp;
  logic [ADC_WIDTH-1:0]   baseline_cap;

  // drop the padding nibble, zero extend back to slot width
  for (genvar i = 0; i < SAMPLES_PER_BEAT; i++) begin : g_fmt
    assign data_fmt[SAMPLE_WIDTH*i +: SAMPLE_WIDTH] =
      {{(SAMPLE_WIDTH - ADC_WIDTH){1'b0}},
       data_q1[SAMPLE_WIDTH*i + SAMPLE_WIDTH-1 -: ADC_WIDTH]};
  end

  // three stage delay, lines up with the trigger decision
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      data_q1  <= '1;
      data_q2  <= '1;
      data_q3  <= '1;
      valid_q1 <= 1'b0;
      valid_q2 <= 1'b0;
      valid_q3 <= 1'b0;
      time_q1  <= '0;
      time_q2  <= '0;
      time_q3  <= '0;
    end else begin
      data_q1  <= TDATA;
      data_q2  <= data_fmt;
      data_q3  <= data_q2;
      valid_q1 <= TVALID;
      valid_q2 <= valid_q1;
      valid_q3 <= valid_q2;
      time_q1  <= CURRENT_TIME;
      time_q2  <= time_q1;
      time_q3  <= time_q2;
    end
  end

  assign trig_rise = triggered & ~trig_q;

  // stamp and baseline are taken once per trigger, held until the next
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      trig_q       <= 1'b0;
      time_stamp   <= '0;
      baseline_cap <= '0;
    end else begin
      trig_q <= triggered;
      if (trig_rise) begin
        time_stamp   <= CURRENT_TIME;
        baseline_cap <= baseline_q;
      end
    end
  end

  assign DOUT  = {data_q3, time_q3, baseline_cap, threshold_q, time_stamp};
  assign VALID = valid_q3;

  a_valid_lat_hi : assert property (
    @(posedge CLK) disable iff (!RESETN)
    TVALID |-> ##3 VALID
  );

  a_valid_lat_lo : assert property (
    @(posedge CLK) disable iff (!RESETN)
    !TVALID |-> ##3 !VALID
  );

endmodule

//--- logic/mm_trigger_top.sv
`timescale 1ns/100ps

module mm_trigger_top (
  input  logic                                      CLK,
  input  logic                                      RESETN,
  input  logic [mm_trg_pkg::TDATA_WIDTH-1:0]        TDATA,
  input  logic                                      TVALID,
  input  logic                                      ALL_MODULE_READY,
  input  logic [mm_trg_pkg::PRE_LEN_WIDTH-1:0]      PRE_ACQUI_LEN,
  input  logic signed [mm_trg_pkg::DELTA_WIDTH-1:0] THRESHOLD_VAL,
  input  logic signed [mm_trg_pkg::ADC_WIDTH-1:0]   BASELINE,
  input  logic [mm_trg_pkg::TIME_WIDTH-1:0]         CURRENT_TIME,
  output logic                                      TRIGGERED,
  output logic [mm_trg_pkg::DOUT_WIDTH-1:0]         DOUT,
  output logic                                      VALID
);
  import mm_trg_pkg::*;

  logic [SAMPLES_PER_BEAT-1:0]   hit_bits;
  logic signed [ADC_WIDTH-1:0]   baseline_q;
  logic signed [DELTA_WIDTH-1:0] threshold_q;
  logic [PRE_LEN_WIDTH-1:0]      pre_len_q;
  logic                          hit_echo;
  logic                          armed;

  sample_compare u_sample_compare (
    .CLK           (CLK),
    .RESETN        (RESETN),
    .TDATA         (TDATA),
    .TVALID        (TVALID),
    .PRE_ACQUI_LEN (PRE_ACQUI_LEN),
    .THRESHOLD_VAL (THRESHOLD_VAL),
    .BASELINE      (BASELINE),
    .hit_bits      (hit_bits),
    .baseline_q    (baseline_q),
    .threshold_q   (threshold_q),
    .pre_len_q     (pre_len_q)
  );

  hit_window u_hit_window (
    .CLK      (CLK),
    .RESETN   (RESETN),
    .hit_bits (hit_bits),
    .armed    (armed),
    .hit_echo (hit_echo)
  );

  trigger_ctrl u_trigger_ctrl (
    .CLK              (CLK),
    .RESETN           (RESETN),
    .TVALID           (TVALID),
    .ALL_MODULE_READY (ALL_MODULE_READY),
    .pre_len_q        (pre_len_q),
    .hit_echo         (hit_echo),
    .armed            (armed),
    .triggered        (TRIGGERED)
  );

  event_capture u_event_capture (
    .CLK          (CLK),
    .RESETN       (RESETN),
    .TDATA        (TDATA),
    .TVALID       (TVALID),
    .CURRENT_TIME (CURRENT_TIME),
    .triggered    (TRIGGERED),
    .baseline_q   (baseline_q),
    .threshold_q  (threshold_q),
    .DOUT         (DOUT),
    .VALID        (VALID)
  );

endmodule

//--- tb/tb_mm_trigger.sv
`timescale 1ns/100ps

module tb_mm_trigger;
  import mm_trg_pkg::*;

  localparam int          PRE_LEN  = 4;
  localparam int          THR_VAL  = 100;
  localparam int          BASE_VAL = -20;
  localparam logic [31:0] SEED     = 32'hce314e71;

  // DOUT field offsets counted up from the time stamp at the lsb end
  localparam int THR_LO  = TIME_WIDTH;
  localparam int BASE_LO = THR_LO + DELTA_WIDTH;
  localparam int TIME_LO = BASE_LO + ADC_WIDTH;
  localparam int DATA_LO = TIME_LO + TIME_WIDTH;

  logic                          CLK = 1'b0;
  logic                          RESETN;
  logic [TDATA_WIDTH-1:0]        tdata;
  logic                          tvalid;
  logic                          all_module_ready;
  logic [PRE_LEN_WIDTH-1:0]      pre_acqui_len;
  logic signed [DELTA_WIDTH-1:0] threshold_val;
  logic signed [ADC_WIDTH-1:0]   baseline;
  logic [TIME_WIDTH-1:0]         current_time;
  logic                          triggered;
  logic [DOUT_WIDTH-1:0]         dout;
  logic                          valid;
  int                            errors;
  int                            timeouts;

  // reference model state
  logic [2:0]             v_sh;
  logic [TDATA_WIDTH-1:0] d0;
  logic [TDATA_WIDTH-1:0] d1;
  logic [TDATA_WIDTH-1:0] d2;
  logic [TIME_WIDTH-1:0]  t0;
  logic [TIME_WIDTH-1:0]  t1;
  logic [TIME_WIDTH-1:0]  t2;
  logic [15:0]            hb_m;
  logic                   flag_m;
  logic                   flag_q_m;
  logic                   echo_m;
  int                     pre_m;
  logic                   armed_m;
  int                     post_m;
  logic                   trig_m;
  logic                   trig_d_m;
  logic [TIME_WIDTH-1:0]  ts_m;
  logic [ADC_WIDTH-1:0]   base_m;

  mm_trigger_top u_mm_trigger_top (
    .CLK              (CLK),
    .RESETN           (RESETN),
    .TDATA            (tdata),
    .TVALID           (tvalid),
    .ALL_MODULE_READY (all_module_ready),
    .PRE_ACQUI_LEN    (pre_acqui_len),
    .THRESHOLD_VAL    (threshold_val),
    .BASELINE         (baseline),
    .CURRENT_TIME     (current_time),
    .TRIGGERED        (triggered),
    .DOUT             (dout),
    .VALID            (valid)
  );

  initial begin
    forever #20 CLK = ~CLK;
  end

  always @(negedge CLK) begin
    current_time <= current_time + 48'd1;
  end

  // slot hits when the signed sample minus baseline reaches the threshold
  function automatic logic [15:0] hits_of(input logic [TDATA_WIDTH-1:0] beat);
    logic [15:0] hits;
    int          s;
    for (int i = 0; i < 16; i++) begin
      s = int'($signed(beat[16*i+4 +: 12]));
      hits[i] = ((s - BASE_VAL) >= THR_VAL);
    end
    return hits;
  endfunction

  function automatic logic [TDATA_WIDTH-1:0] zext_samples(input logic [TDATA_WIDTH-1:0] beat);
    logic [TDATA_WIDTH-1:0] out;
    for (int i = 0; i < 16; i++) begin
      out[16*i +: 16] = {4'h0, beat[16*i+4 +: 12]};
    end
    return out;
  endfunction

  assign echo_m = flag_m | flag_q_m;

  always @(posedge CLK) begin
    if (!RESETN) begin
      v_sh     <= '0;
      d0       <= '1;
      d1       <= '1;
      d2       <= '1;
      t0       <= '0;
      t1       <= '0;
      t2       <= '0;
      hb_m     <= '0;
      flag_m   <= 1'b0;
      flag_q_m <= 1'b0;
      pre_m    <= 0;
      armed_m  <= 1'b0;
      post_m   <= 0;
      trig_m   <= 1'b0;
      trig_d_m <= 1'b0;
      ts_m     <= '0;
      base_m   <= '0;
    end else begin
      v_sh <= {v_sh[1:0], tvalid};
      d0   <= tdata;
      d1   <= zext_samples(d0);
      d2   <= d1;
      t0   <= current_time;
      t1   <= t0;
      t2   <= t1;
      hb_m <= tvalid ? hits_of(tdata) : 16'h0000;
      // a window needs all eight of its samples
      flag_m   <= armed_m & ((&hb_m[7:0]) | (&hb_m[15:8]));
      flag_q_m <= armed_m & flag_m;
      if (!tvalid) begin
        pre_m <= 0;
      end else if (pre_m != PRE_LEN - 1) begin
        pre_m <= pre_m + 1;
      end
      armed_m <= tvalid & all_module_ready & (pre_m == PRE_LEN - 1);
      if (!armed_m || echo_m) begin
        post_m <= 0;
      end else if (post_m != POST_ACQUI_LEN - 1) begin
        post_m <= post_m + 1;
      end
      if (!armed_m) begin
        trig_m <= 1'b0;
      end else if (echo_m) begin
        trig_m <= 1'b1;
      end else if (post_m == POST_ACQUI_LEN - 1) begin
        trig_m <= 1'b0;
      end
      trig_d_m <= trig_m;
      if (trig_m && !trig_d_m) begin
        ts_m   <= current_time;
        base_m <= 12'(BASE_VAL);
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [255:0] exp,
                                 input logic [255:0] act);
    errors++;
    $display("FAILED t=%0t %s exp=%0h act=%0h", $time, name, exp, act);
  endtask

  a_valid : assert property (@(posedge CLK) disable iff (!RESETN) valid == v_sh[2])
    else report_mismatch("VALID", 256'(v_sh[2]), 256'(valid));
  a_data : assert property (@(posedge CLK) disable iff (!RESETN)
    dout[DATA_LO +: TDATA_WIDTH] == d2)
    else report_mismatch("DOUT.data", d2, dout[DATA_LO +: TDATA_WIDTH]);
  a_time : assert property (@(posedge CLK) disable iff (!RESETN)
    dout[TIME_LO +: TIME_WIDTH] == t2)
    else report_mismatch("DOUT.time", 256'(t2), 256'(dout[TIME_LO +: TIME_WIDTH]));
  a_base : assert property (@(posedge CLK) disable iff (!RESETN)
    dout[BASE_LO +: ADC_WIDTH] == base_m)
    else report_mismatch("DOUT.baseline", 256'(base_m), 256'(dout[BASE_LO +: ADC_WIDTH]));
  a_thr : assert property (@(posedge CLK) disable iff (!RESETN)
    dout[THR_LO +: DELTA_WIDTH] == 13'(THR_VAL))
    else report_mismatch("DOUT.threshold", 256'(13'(THR_VAL)),
                         256'(dout[THR_LO +: DELTA_WIDTH]));
  a_stamp : assert property (@(posedge CLK) disable iff (!RESETN)
    dout[TIME_WIDTH-1:0] == ts_m)
    else report_mismatch("DOUT.time_stamp", 256'(ts_m), 256'(dout[TIME_WIDTH-1:0]));
  a_trig : assert property (@(posedge CLK) disable iff (!RESETN) triggered == trig_m)
    else report_mismatch("TRIGGERED", 256'(trig_m), 256'(triggered));

  // each set mask bit plants a qualifying sample in its slot
  task automatic send_beat(input logic vld, input logic [15:0] mask);
    logic [TDATA_WIDTH-1:0] beat;
    logic [31:0]            r;
    int                     s;
    @(negedge CLK);
    for (int i = 0; i < 16; i++) begin
      r = $urandom;
      if (mask[i]) begin
        s = THR_VAL + BASE_VAL + int'(r[15:8]);
      end else begin
        s = int'(r[15:4] % 12'd160) - 80;
      end
      beat[16*i +: 16] = {s[11:0], r[3:0]};
    end
    tdata  = beat;
    tvalid = vld;
  endtask

  task automatic wait_trig(input logic level, input int limit);
    int n;
    n = 0;
    while (triggered !== level && n < limit) begin
      send_beat(1'b1, 16'h0000);
      n++;
    end
    if (triggered !== level) begin
      timeouts++;
      $display("timeout after %0d cycles waiting for TRIGGERED = %0b", limit, level);
    end
  endtask

  initial begin
    logic [31:0] r;
    r                = $urandom(SEED);
    errors           = 0;
    timeouts         = 0;
    RESETN           = 1'b0;
    tdata            = '0;
    tvalid           = 1'b0;
    all_module_ready = 1'b0;
    pre_acqui_len    = 5'(PRE_LEN);
    threshold_val    = 13'(THR_VAL);
    baseline         = 12'(BASE_VAL);
    current_time     = 48'h1000;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RESETN = 1'b1;

    // hits before the pre-acquisition count is reached
    all_module_ready = 1'b1;
    send_beat(1'b1, 16'h00FF);
    send_beat(1'b1, 16'hFF00);
    send_beat(1'b0, 16'hFFFF);
    send_beat(1'b1, 16'hFFFF);
    send_beat(1'b1, 16'h0000);

    // downstream not ready
    all_module_ready = 1'b0;
    repeat (6) send_beat(1'b1, 16'h0000);
    send_beat(1'b1, 16'hFFFF);
    repeat (4) send_beat(1'b1, 16'h0000);
    all_module_ready = 1'b1;
    repeat (4) send_beat(1'b1, 16'h0000);

    // single full window while armed
    send_beat(1'b1, 16'h00FF);
    wait_trig(1'b1, 8);
    wait_trig(1'b0, 60);

    // seven samples in one window and eight split over both
    send_beat(1'b1, 16'h007F);
    send_beat(1'b1, 16'h0F0F);
    send_beat(1'b1, 16'hFE00);
    repeat (6) send_beat(1'b1, 16'h0000);

    // second hit during the hold
    send_beat(1'b1, 16'hFF00);
    wait_trig(1'b1, 8);
    repeat (20) send_beat(1'b1, 16'h0000);
    send_beat(1'b1, 16'hFFFF);
    repeat (3) send_beat(1'b1, 16'h0000);
    wait_trig(1'b0, 60);

    // readiness lost while fired
    send_beat(1'b1, 16'h00FF);
    wait_trig(1'b1, 8);
    repeat (3) send_beat(1'b1, 16'h0000);
    all_module_ready = 1'b0;
    wait_trig(1'b0, 2);
    all_module_ready = 1'b1;

    // random traffic with gaps and occasional hits
    repeat (300) begin
      r = $urandom;
      send_beat(|r[7:5], (r[3:0] == 4'd0) ? (r[4] ? 16'hFF00 : 16'h00FF) : 16'h0000);
    end
    repeat (4) send_beat(1'b0, 16'h0000);

    $display("run complete: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
logic/mm_trg_pkg.sv
logic/sample_compare.sv
logic/hit_window.sv
logic/trigger_ctrl.sv
logic/event_capture.sv
logic/mm_trigger_top.sv
tb/tb_mm_trigger.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the trigger testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_mm_trigger \
  -Mdir obj_dir \
  -f tb.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_mm_trigger)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
